// ==== design/i2c_slave_pkg.sv ====
// I2C slave shared definitions
`default_nettype none

package i2c_slave_pkg;

    localparam int AXI_ADDR_W = 4;

    // Register offsets
    localparam logic [AXI_ADDR_W-1:0] REG_PRIMARY   = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_SECONDARY = 4'h1;
    localparam logic [AXI_ADDR_W-1:0] REG_RX_DATA   = 4'h2;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 4'h3;

    // Status register bits
    localparam int STAT_NOT_EMPTY = 0;
    localparam int STAT_SEC_HIT   = 1;
    localparam int STAT_OVERFLOW  = 2;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Receive FIFO, depth must be a power of two
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [6:0] i2c_addr_t;

    typedef struct packed {
        i2c_addr_t addr;
        logic      rw;
    } i2c_addr_field_t;

    // First byte after START is an address field, later bytes are data
    typedef union packed {
        i2c_addr_field_t addr_view;
        logic [7:0]      data;
    } i2c_byte_u;

    typedef struct packed {
        logic       sec_hit;
        logic [7:0] data;
    } rx_item_t;

endpackage

`default_nettype wire

// ==== design/i2c_rx_frontend.sv ====
// I2C receive front end
`default_nettype none

module i2c_rx_frontend (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           scl,
    input  wire                           sda,
    input  wire i2c_slave_pkg::i2c_addr_t primary_addr,
    input  wire i2c_slave_pkg::i2c_addr_t secondary_addr,
    input  wire                           full,
    output logic                          push,
    output i2c_slave_pkg::rx_item_t       push_item,
    output logic                          overflow,
    output logic                          sda_oe
);
    import i2c_slave_pkg::*;

    typedef struct packed {
        logic scl;
        logic sda;
    } pins_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_ACK
    } state_t;

    pins_t      pin_meta;
    pins_t      pin_sync;
    pins_t      pin_prev;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_det;
    logic       stop_det;
    logic       byte_done;
    state_t     state;
    logic [2:0] bit_cnt;
    logic [6:0] shreg;
    i2c_byte_u  rx_byte;
    logic       prim_match;
    logic       sec_match;
    logic       ack_go;
    logic       ack_phase;
    logic       sec_sel;

    // Bus idles high, so the synchroniser resets to ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pin_meta <= '1;
            pin_sync <= '1;
            pin_prev <= '1;
        end else begin
            pin_meta <= {scl, sda};
            pin_sync <= pin_meta;
            pin_prev <= pin_sync;
        end
    end

    assign scl_rise  = pin_sync.scl && !pin_prev.scl;
    assign scl_fall  = !pin_sync.scl && pin_prev.scl;
    assign start_det = pin_sync.scl && pin_prev.scl && pin_prev.sda && !pin_sync.sda;
    assign stop_det  = pin_sync.scl && pin_prev.scl && !pin_prev.sda && pin_sync.sda;
    assign byte_done = scl_rise && (bit_cnt == 3'd7);

    // Byte as it stands including the bit sampled now
    assign rx_byte    = {shreg, pin_sync.sda};
    assign prim_match = (rx_byte.addr_view.addr == primary_addr);
    assign sec_match  = (rx_byte.addr_view.addr == secondary_addr);

    always_ff @(posedge clk) begin
        if (scl_rise && (state == ST_ADDR || state == ST_DATA)) begin
            shreg <= rx_byte.data[6:0];
        end
        if (state == ST_DATA && byte_done) begin
            push_item <= '{sec_hit: sec_sel, data: rx_byte.data};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            ack_go    <= 1'b0;
            ack_phase <= 1'b0;
            sec_sel   <= 1'b0;
            sda_oe    <= 1'b0;
            push      <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            push     <= 1'b0;
            overflow <= 1'b0;
            if (start_det) begin
                // Also covers a repeated START
                state   <= ST_ADDR;
                bit_cnt <= '0;
                sda_oe  <= 1'b0;
            end else if (stop_det) begin
                state  <= ST_IDLE;
                sda_oe <= 1'b0;
            end else begin
                case (state)
                    ST_ADDR: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                        if (byte_done) begin
                            if (!rx_byte.addr_view.rw && (prim_match || sec_match)) begin
                                state     <= ST_ACK;
                                ack_go    <= 1'b1;
                                ack_phase <= 1'b0;
                                sec_sel   <= !prim_match;
                            end else begin
                                state <= ST_IDLE;
                            end
                        end
                    end
                    ST_DATA: begin
                        if (scl_rise) begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                        if (byte_done) begin
                            state     <= ST_ACK;
                            ack_go    <= !full;
                            ack_phase <= 1'b0;
                            push      <= !full;
                            overflow  <= full;
                        end
                    end
                    ST_ACK: begin
                        // Drive from the falling edge after bit 8 to the next one
                        if (scl_fall) begin
                            if (!ack_phase) begin
                                sda_oe    <= ack_go;
                                ack_phase <= 1'b1;
                            end else begin
                                sda_oe <= 1'b0;
                                state  <= ST_DATA;
                            end
                        end
                    end
                    default: begin
                        sda_oe <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rx_fifo.sv ====
// Receive byte FIFO
`default_nettype none

module rx_fifo (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          push,
    input  wire i2c_slave_pkg::rx_item_t push_item,
    input  wire                          pop,
    output i2c_slave_pkg::rx_item_t      head,
    output logic                         empty,
    output logic                         full
);
    import i2c_slave_pkg::*;

    rx_item_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W:0]   wr_ptr;
    logic [FIFO_PTR_W:0]   rd_ptr;
    logic [FIFO_PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[FIFO_PTR_W-1:0]] <= push_item;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Extra pointer bit tells full from empty
    assign count = wr_ptr - rd_ptr;
    assign empty = (count == '0);
    assign full  = (count == FIFO_DEPTH);
    assign head  = mem[rd_ptr[FIFO_PTR_W-1:0]];

endmodule

`default_nettype wire

// ==== design/axil_regs.sv ====
// AXI4-Lite register block
`default_nettype none

module axil_regs (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire [i2c_slave_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  wire                                  s_axi_awvalid,
    output logic                                 s_axi_awready,
    input  wire [7:0]                            s_axi_wdata,
    input  wire [0:0]                            s_axi_wstrb,
    input  wire                                  s_axi_wvalid,
    output logic                                 s_axi_wready,
    output logic [1:0]                           s_axi_bresp,
    output logic                                 s_axi_bvalid,
    input  wire                                  s_axi_bready,
    input  wire [i2c_slave_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  wire                                  s_axi_arvalid,
    output logic                                 s_axi_arready,
    output logic [7:0]                           s_axi_rdata,
    output logic [1:0]                           s_axi_rresp,
    output logic                                 s_axi_rvalid,
    input  wire                                  s_axi_rready,
    input  wire i2c_slave_pkg::rx_item_t         head,
    input  wire                                  empty,
    output logic                                 pop,
    input  wire                                  overflow,
    output i2c_slave_pkg::i2c_addr_t             primary_addr,
    output i2c_slave_pkg::i2c_addr_t             secondary_addr
);
    import i2c_slave_pkg::*;

    logic       wr_start;
    logic       wr_go;
    logic       wr_en;
    logic       rd_go;
    logic       ovf_flag;
    logic [7:0] status;
    logic [7:0] rd_value;

    // AW and W are taken together, one transfer in flight at a time
    assign wr_start = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
    assign wr_go    = s_axi_awready && s_axi_wready && s_axi_awvalid && s_axi_wvalid;
    assign wr_en    = wr_go && s_axi_wstrb[0];
    assign rd_go    = s_axi_arready && s_axi_arvalid;
    assign pop      = rd_go && (s_axi_araddr == REG_RX_DATA) && !empty;

    assign s_axi_bresp = RESP_OKAY;
    assign s_axi_rresp = RESP_OKAY;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_awready <= wr_start;
            s_axi_wready  <= wr_start;
            if (wr_go) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            s_axi_arready <= s_axi_arvalid && !s_axi_rvalid && !s_axi_arready;
            if (rd_go) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            primary_addr   <= '0;
            secondary_addr <= '0;
            ovf_flag       <= 1'b0;
        end else begin
            if (wr_en && s_axi_awaddr == REG_PRIMARY) begin
                primary_addr <= s_axi_wdata[6:0];
            end
            if (wr_en && s_axi_awaddr == REG_SECONDARY) begin
                secondary_addr <= s_axi_wdata[6:0];
            end
            // A new overflow wins over a clear in the same cycle
            if (overflow) begin
                ovf_flag <= 1'b1;
            end else if (wr_en && s_axi_awaddr == REG_STATUS) begin
                ovf_flag <= 1'b0;
            end
        end
    end

    always_comb begin
        status                 = '0;
        status[STAT_NOT_EMPTY] = !empty;
        status[STAT_SEC_HIT]   = !empty && head.sec_hit;
        status[STAT_OVERFLOW]  = ovf_flag;
    end

    always_comb begin
        case (s_axi_araddr)
            REG_PRIMARY:   rd_value = {1'b0, primary_addr};
            REG_SECONDARY: rd_value = {1'b0, secondary_addr};
            REG_RX_DATA:   rd_value = empty ? 8'h00 : head.data;
            REG_STATUS:    rd_value = status;
            default:       rd_value = 8'h00;
        endcase
    end

    // Only loaded while rvalid is low, so data holds until rready
    always_ff @(posedge clk) begin
        if (rd_go) begin
            s_axi_rdata <= rd_value;
        end
    end

endmodule

`default_nettype wire

// ==== design/i2c_slave_top.sv ====
// I2C write slave top level
`default_nettype none

module i2c_slave_top (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  scl,
    input  wire                                  sda,
    output logic                                 sda_oe,
    input  wire [i2c_slave_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  wire                                  s_axi_awvalid,
    output logic                                 s_axi_awready,
    input  wire [7:0]                            s_axi_wdata,
    input  wire [0:0]                            s_axi_wstrb,
    input  wire                                  s_axi_wvalid,
    output logic                                 s_axi_wready,
    output logic [1:0]                           s_axi_bresp,
    output logic                                 s_axi_bvalid,
    input  wire                                  s_axi_bready,
    input  wire [i2c_slave_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  wire                                  s_axi_arvalid,
    output logic                                 s_axi_arready,
    output logic [7:0]                           s_axi_rdata,
    output logic [1:0]                           s_axi_rresp,
    output logic                                 s_axi_rvalid,
    input  wire                                  s_axi_rready
);
    import i2c_slave_pkg::*;

    logic      push;
    rx_item_t  push_item;
    logic      full;
    logic      overflow;
    rx_item_t  head;
    logic      empty;
    logic      pop;
    i2c_addr_t primary_addr;
    i2c_addr_t secondary_addr;

    i2c_rx_frontend u_frontend (
        .clk            (clk),
        .rst            (rst),
        .scl            (scl),
        .sda            (sda),
        .primary_addr   (primary_addr),
        .secondary_addr (secondary_addr),
        .full           (full),
        .push           (push),
        .push_item      (push_item),
        .overflow       (overflow),
        .sda_oe         (sda_oe)
    );

    rx_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    axil_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wstrb    (s_axi_wstrb),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .head           (head),
        .empty          (empty),
        .pop            (pop),
        .overflow       (overflow),
        .primary_addr   (primary_addr),
        .secondary_addr (secondary_addr)
    );

endmodule

`default_nettype wire

// ==== sim/i2c_slave_chk.sv ====
// AXI and ACK protocol checker
`default_nettype none

module i2c_slave_chk (
    input wire       clk,
    input wire       rst,
    input wire       sda_oe,
    input wire       s_axi_awready,
    input wire       s_axi_wready,
    input wire       s_axi_bvalid,
    input wire       s_axi_bready,
    input wire [7:0] s_axi_rdata,
    input wire       s_axi_rvalid,
    input wire       s_axi_rready
);

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // Read data frozen while the master stalls
    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("read response changed while rready low");

    // AW and W accepted together in a single-cycle pulse
    aw_with_w: assert property (@(posedge clk) disable iff (rst)
        s_axi_awready |-> s_axi_wready ##1 !(s_axi_awready || s_axi_wready))
        else $error("awready without wready or held past one cycle");

    ack_reset: assert property (@(posedge clk) rst |-> !sda_oe)
        else $error("sda_oe driven during reset");

endmodule

bind i2c_slave_top i2c_slave_chk u_chk (.*);

`default_nettype wire

// ==== sim/tb_top.sv ====
// I2C write slave testbench
`default_nettype none

module tb_top;
    import i2c_slave_pkg::*;

    localparam int HALF     = 8;
    localparam int QTR      = 4;
    localparam int WAIT_MAX = 400;

    logic                  clk;
    logic                  rst;
    logic                  scl;
    logic                  sda_low;
    logic                  sda_oe;
    wire                   sda_line;
    logic [AXI_ADDR_W-1:0] s_axi_awaddr;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [7:0]            s_axi_wdata;
    logic [0:0]            s_axi_wstrb;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [AXI_ADDR_W-1:0] s_axi_araddr;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [7:0]            s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_errs;
    rx_item_t    model_q[$];
    i2c_addr_t   model_prim;
    i2c_addr_t   model_sec;
    logic        model_ovf;

    // Open-drain bus, low when master or slave pulls
    assign sda_line = !(sda_low || sda_oe);

    i2c_slave_top dut (.sda(sda_line), .*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        repeat (200000) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] expected_status();
        logic [7:0] s;
        s = '0;
        if (model_q.size() > 0) begin
            s[STAT_NOT_EMPTY] = 1'b1;
            s[STAT_SEC_HIT]   = model_q[0].sec_hit;
        end
        s[STAT_OVERFLOW] = model_ovf;
        return s;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at t=%0t while waiting for %s", $time, what);
        errors++;
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [7:0] data,
                             input logic strb);
        int t;
        int hold;
        @(negedge clk);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = 1'b0;
        hold = rand_bits(2);
        t = 0;
        while (!s_axi_awready && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (t == WAIT_MAX) begin
            report_timeout("awready");
        end else begin
            check_eq("wready", s_axi_wready, 1'b1);
        end
        // Handshake completes on the edge before this one
        @(negedge clk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        t = 0;
        while (!s_axi_bvalid && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (t == WAIT_MAX) begin
            report_timeout("bvalid");
        end else begin
            check_eq("bresp", s_axi_bresp, RESP_OKAY);
        end
        // Master stalls the write response for a few cycles
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_eq("bvalid", s_axi_bvalid, 1'b1);
        end
        s_axi_bready = 1'b1;
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int hold,
                            output logic [7:0] data);
        int t;
        @(negedge clk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = 1'b0;
        t = 0;
        while (!s_axi_arready && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (t == WAIT_MAX) report_timeout("arready");
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        t = 0;
        while (!s_axi_rvalid && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (t == WAIT_MAX) report_timeout("rvalid");
        data = s_axi_rdata;
        check_eq("rresp", s_axi_rresp, RESP_OKAY);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_eq("rvalid", s_axi_rvalid, 1'b1);
            check_eq("rdata", s_axi_rdata, data);
        end
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    task automatic read_check(input logic [AXI_ADDR_W-1:0] addr, input logic [7:0] exp,
                              input string name);
        logic [7:0] d;
        axi_read(addr, 0, d);
        check_eq(name, d, exp);
    endtask

    task automatic i2c_start();
        @(negedge clk);
        sda_low = 1'b1;
        repeat (HALF) @(negedge clk);
        scl = 1'b0;
        repeat (QTR) @(negedge clk);
    endtask

    // Data changes only in the middle of scl low
    task automatic i2c_bit(input logic b);
        sda_low = !b;
        repeat (QTR) @(negedge clk);
        scl = 1'b1;
        repeat (HALF) @(negedge clk);
        scl = 1'b0;
        repeat (QTR) @(negedge clk);
    endtask

    task automatic i2c_byte(input logic [7:0] b, output logic ack);
        for (int i = 7; i >= 0; i--) begin
            i2c_bit(b[i]);
        end
        sda_low = 1'b0;
        repeat (QTR) @(negedge clk);
        scl = 1'b1;
        repeat (HALF) @(negedge clk);
        ack = !sda_line;
        scl = 1'b0;
        repeat (QTR) @(negedge clk);
    endtask

    task automatic i2c_stop();
        sda_low = 1'b1;
        repeat (QTR) @(negedge clk);
        scl = 1'b1;
        repeat (HALF) @(negedge clk);
        sda_low = 1'b0;
        repeat (HALF) @(negedge clk);
    endtask

    // Data bytes follow even a NACKed address, a silent slave must ignore them
    task automatic send_transfer(input i2c_addr_t addr, input logic rw, input int n,
                                 input logic addr_ack, input logic sec);
        logic       ack;
        logic       exp;
        logic [7:0] d;
        i2c_start();
        i2c_byte({addr, rw}, ack);
        check_eq("addr_ack", ack, addr_ack);
        for (int i = 0; i < n; i++) begin
            d   = 8'(rand_bits(8));
            exp = addr_ack && (model_q.size() < FIFO_DEPTH);
            i2c_byte(d, ack);
            check_eq("data_ack", ack, exp);
            if (exp) begin
                model_q.push_back('{sec_hit: sec, data: d});
            end else if (addr_ack) begin
                model_ovf = 1'b1;
            end
        end
        i2c_stop();
    endtask

    task automatic wait_not_empty();
        logic [7:0] st;
        int         t;
        st = '0;
        t  = 0;
        while (!st[STAT_NOT_EMPTY] && t < 50) begin
            axi_read(REG_STATUS, 0, st);
            t++;
        end
        if (!st[STAT_NOT_EMPTY]) report_timeout("STATUS not-empty");
    endtask

    task automatic drain_check();
        rx_item_t it;
        while (model_q.size() > 0) begin
            read_check(REG_STATUS, expected_status(), "status");
            it = model_q.pop_front();
            read_check(REG_RX_DATA, it.data, "rx_data");
        end
        read_check(REG_STATUS, expected_status(), "status");
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %s (%0d errors)", num, name,
                 (errors == test_errs) ? "ok" : "FAILED", errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        logic [7:0] v;
        logic [7:0] d;
        logic       s;
        i2c_addr_t  a;
        lfsr          = 32'h7650f4f1;
        errors        = 0;
        checks        = 0;
        test_errs     = 0;
        model_prim    = '0;
        model_sec     = '0;
        model_ovf     = 1'b0;
        rst           = 1'b1;
        scl           = 1'b1;
        sda_low       = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        read_check(REG_STATUS, 8'h00, "status");
        read_check(REG_PRIMARY, 8'h00, "primary");
        read_check(REG_SECONDARY, 8'h00, "secondary");
        for (int i = 0; i < 4; i++) begin
            v = 8'(rand_bits(8));
            axi_write(REG_PRIMARY, v, 1'b1);
            model_prim = v[6:0];
            v = 8'(rand_bits(8));
            axi_write(REG_SECONDARY, v, 1'b1);
            model_sec = v[6:0];
            read_check(REG_PRIMARY, {1'b0, model_prim}, "primary");
            read_check(REG_SECONDARY, {1'b0, model_sec}, "secondary");
        end
        // Data differs from the register so a wrong write shows
        axi_write(REG_PRIMARY, {1'b0, ~model_prim}, 1'b0);
        read_check(REG_PRIMARY, {1'b0, model_prim}, "primary");
        for (int i = 0; i < 4; i++) begin
            read_check(AXI_ADDR_W'(4 + rand_bits(3)), 8'h00, "unmapped");
        end
        end_test(1, "register access");

        a = i2c_addr_t'(rand_bits(7));
        model_prim = a;
        axi_write(REG_PRIMARY, {1'b0, a}, 1'b1);
        while (a == model_prim) begin
            a = i2c_addr_t'(rand_bits(7));
        end
        model_sec = a;
        axi_write(REG_SECONDARY, {1'b0, a}, 1'b1);
        for (int p = 0; p < 3; p++) begin
            s = 1'(rand_bits(1));
            send_transfer(s ? model_sec : model_prim, 1'b0, 1 + rand_bits(2), 1'b1, s);
            send_transfer(s ? model_prim : model_sec, 1'b0, 1 + rand_bits(2), 1'b1, !s);
            wait_not_empty();
            drain_check();
        end
        end_test(2, "two-address writes");

        a = i2c_addr_t'(rand_bits(7));
        while (a == model_prim || a == model_sec) begin
            a = i2c_addr_t'(rand_bits(7));
        end
        send_transfer(a, 1'b0, 2, 1'b0, 1'b0);
        send_transfer(model_prim, 1'b1, 2, 1'b0, 1'b0);
        read_check(REG_STATUS, expected_status(), "status");
        end_test(3, "address NACK");

        send_transfer(model_prim, 1'b0, FIFO_DEPTH + 3, 1'b1, 1'b0);
        wait_not_empty();
        drain_check();
        axi_write(REG_STATUS, 8'(rand_bits(8)), 1'b1);
        model_ovf = 1'b0;
        read_check(REG_STATUS, expected_status(), "status");
        end_test(4, "FIFO overflow");

        send_transfer(model_sec, 1'b0, 2, 1'b1, 1'b1);
        wait_not_empty();
        axi_read(REG_RX_DATA, 1 + rand_bits(4), d);
        check_eq("rx_data", d, model_q[0].data);
        void'(model_q.pop_front());
        read_check(REG_RX_DATA, model_q[0].data, "rx_data");
        void'(model_q.pop_front());
        read_check(REG_STATUS, expected_status(), "status");
        end_test(5, "read stall");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/i2c_slave_pkg.sv
design/i2c_rx_frontend.sv
design/rx_fifo.sv
design/axil_regs.sv
design/i2c_slave_top.sv
sim/i2c_slave_chk.sv
sim/tb_top.sv

// ==== Bender.yml ====
package:
  name: i2c_slave

sources:
  - design/i2c_slave_pkg.sv
  - design/i2c_rx_frontend.sv
  - design/rx_fifo.sv
  - design/axil_regs.sv
  - design/i2c_slave_top.sv
  - target: simulation
    files:
      - sim/i2c_slave_chk.sv
      - sim/tb_top.sv
